// File: rtl/hack_pkg.sv
// Hack CPU shared constants: word width, instruction fields and APB register map

package hack_pkg;

    // ============================================================
    // Widths
    // ============================================================
    localparam int data_w     = 16;
    localparam int apb_addr_w = 8;

    // ============================================================
    // C-instruction field positions
    // ============================================================
    // Selects M instead of A on the ALU y input
    localparam int a_bit_pos  = 12;

    // zx nx zy ny f no, from msb down
    localparam int comp_msb   = 11;
    localparam int comp_lsb   = 6;

    localparam int dest_a_pos = 5;
    localparam int dest_d_pos = 4;
    localparam int dest_m_pos = 3;

    // Bit 15 of the instruction word
    typedef enum logic {
        instr_a = 1'b0,
        instr_c = 1'b1
    } instr_kind_e;

    // APB byte offsets
    typedef enum logic [7:0] {
        reg_instr      = 8'h00,
        reg_a          = 8'h04,
        reg_d          = 8'h08,
        reg_out_m      = 8'h0C,
        reg_status     = 8'h10,
        reg_exec_count = 8'h14
    } reg_offset_e;

endpackage

// File: rtl/hack_alu.sv
// Hack ALU: zero/negate on both inputs, add or and, optional output negate, flags
`timescale 1ns/1ns

module hack_alu
    import hack_pkg::*;
(
    input  logic [data_w-1:0] x,
    input  logic [data_w-1:0] y,
    input  logic [5:0]        comp,
    output logic [data_w-1:0] out,
    output logic              zr,
    output logic              ng
);

    logic zx, nx, zy, ny, f, no;

    logic [data_w-1:0] x_zero, x_pre;
    logic [data_w-1:0] y_zero, y_pre;
    logic [data_w-1:0] f_out;

    assign {zx, nx, zy, ny, f, no} = comp;

    always_comb begin
        x_zero = zx ? '0 : x;
        x_pre  = nx ? ~x_zero : x_zero;

        y_zero = zy ? '0 : y;
        y_pre  = ny ? ~y_zero : y_zero;

        // Sum wraps at word width
        f_out  = f ? (x_pre + y_pre) : (x_pre & y_pre);
        out    = no ? ~f_out : f_out;
    end

    // Flags
    assign zr = (out == '0);
    assign ng = out[data_w-1];

endmodule

// File: rtl/hack_ram.sv
// Hack data memory: word addressed, combinational read, clocked write
`timescale 1ns/1ns

module hack_ram
    import hack_pkg::*;
#(
    parameter int ram_addr_w = 10
) (
    input  logic                  clk_100MHz,
    input  logic [ram_addr_w-1:0] addr,
    input  logic [data_w-1:0]     wdata,
    input  logic                  we,
    output logic [data_w-1:0]     rdata
);

    localparam int depth = 1 << ram_addr_w;

    logic [data_w-1:0] mem [0:depth-1];

    // Start from an all-zero memory
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk_100MHz) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    assign rdata = mem[addr];

endmodule

// File: rtl/hack_core.sv
// Hack core: decodes one instruction, runs the ALU and commits to A, D and memory
`timescale 1ns/1ns

module hack_core
    import hack_pkg::*;
#(
    parameter int ram_addr_w = 10
) (
    input  logic              clk_100MHz,
    input  logic              reset,
    input  logic [data_w-1:0] instr,
    input  logic              exec_valid,
    output logic [data_w-1:0] a_value,
    output logic [data_w-1:0] d_value,
    output logic [data_w-1:0] out_m,
    output logic              zr,
    output logic              ng,
    output logic              write_m,
    output logic [data_w-1:0] exec_count
);

    instr_kind_e       kind;
    logic [data_w-1:0] m_value;
    logic [data_w-1:0] alu_y;
    logic              mem_we;

    // ============================================================
    // Decode
    // ============================================================
    assign kind    = instr_kind_e'(instr[data_w-1]);
    assign alu_y   = instr[a_bit_pos] ? m_value : a_value;
    assign write_m = (kind == instr_c) && instr[dest_m_pos];
    assign mem_we  = write_m && exec_valid;

    hack_alu i_hack_alu (
        .x    (d_value),
        .y    (alu_y),
        .comp (instr[comp_msb:comp_lsb]),
        .out  (out_m),
        .zr   (zr),
        .ng   (ng)
    );

    // Address comes from A before the commit edge
    hack_ram #(
        .ram_addr_w (ram_addr_w)
    ) i_hack_ram (
        .clk_100MHz (clk_100MHz),
        .addr       (a_value[ram_addr_w-1:0]),
        .wdata      (out_m),
        .we         (mem_we),
        .rdata      (m_value)
    );

    // ============================================================
    // Execute
    // ============================================================
    always_ff @(posedge clk_100MHz or posedge reset) begin
        if (reset) begin
            a_value    <= '0;
            d_value    <= '0;
            exec_count <= '0;
        end else if (exec_valid) begin
            exec_count <= exec_count + 1'b1;
            if (kind == instr_a) begin
                a_value <= {1'b0, instr[data_w-2:0]};
            end else begin
                if (instr[dest_a_pos]) begin
                    a_value <= out_m;
                end
                if (instr[dest_d_pos]) begin
                    d_value <= out_m;
                end
            end
        end
    end

    // A memory write only happens as part of a counted execute step
    assert property (@(posedge clk_100MHz) disable iff (reset)
        mem_we |-> exec_valid ##1 (exec_count == $past(exec_count) + 1'b1));

endmodule

// File: rtl/hack_apb_regs.sv
// APB register block: instruction register, execute strobe and core readback
`timescale 1ns/1ns

module hack_apb_regs
    import hack_pkg::*;
(
    input  logic                  clk_100MHz,
    input  logic                  reset,
    input  logic [apb_addr_w-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic [data_w-1:0]     instr,
    output logic                  exec_valid,
    input  logic [data_w-1:0]     a_value,
    input  logic [data_w-1:0]     d_value,
    input  logic [data_w-1:0]     out_m,
    input  logic                  zr,
    input  logic                  ng,
    input  logic                  write_m,
    input  logic [data_w-1:0]     exec_count
);

    logic        access;
    logic        mapped;
    logic        is_instr;
    logic        instr_wr;
    logic [31:0] rdata_mux;

    // ============================================================
    // Address decode and readback
    // ============================================================
    always_comb begin
        mapped    = 1'b1;
        is_instr  = 1'b0;
        rdata_mux = '0;
        case (paddr)
            reg_instr: begin
                is_instr  = 1'b1;
                rdata_mux = {16'h0000, instr};
            end
            reg_a:          rdata_mux = {16'h0000, a_value};
            reg_d:          rdata_mux = {16'h0000, d_value};
            reg_out_m:      rdata_mux = {16'h0000, out_m};
            reg_status:     rdata_mux = {29'd0, write_m, ng, zr};
            reg_exec_count: rdata_mux = {16'h0000, exec_count};
            default:        mapped    = 1'b0;
        endcase
    end

    // No wait states
    assign pready   = 1'b1;
    assign access   = psel && penable;
    assign instr_wr = access && pwrite && is_instr;
    assign prdata   = rdata_mux;
    assign pslverr  = access && (!mapped || (pwrite && !is_instr));

    // ============================================================
    // Instruction register and execute strobe
    // ============================================================
    always_ff @(posedge clk_100MHz or posedge reset) begin
        if (reset) begin
            instr      <= '0;
            exec_valid <= 1'b0;
        end else begin
            exec_valid <= instr_wr;
            if (instr_wr) begin
                instr <= pwdata[data_w-1:0];
            end
        end
    end

    assert property (@(posedge clk_100MHz) disable iff (reset)
        penable |-> psel);

    // Two-cycle transfers keep the strobe isolated
    assert property (@(posedge clk_100MHz) disable iff (reset)
        exec_valid |=> !exec_valid);

endmodule

// File: rtl/hack_top.sv
// Hack CPU top: APB register block driving the single-step processor core
`timescale 1ns/1ns

module hack_top
    import hack_pkg::*;
#(
    parameter int ram_addr_w = 10
) (
    input  logic                  clk_100MHz,
    input  logic                  reset,
    input  logic [apb_addr_w-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [31:0]           pwdata,
    output logic [31:0]           prdata,
    output logic                  pready,
    output logic                  pslverr
);

    logic [data_w-1:0] instr;
    logic              exec_valid;
    logic [data_w-1:0] a_value;
    logic [data_w-1:0] d_value;
    logic [data_w-1:0] out_m;
    logic              zr;
    logic              ng;
    logic              write_m;
    logic [data_w-1:0] exec_count;

    hack_apb_regs i_hack_apb_regs (
        .clk_100MHz (clk_100MHz),
        .reset      (reset),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .instr      (instr),
        .exec_valid (exec_valid),
        .a_value    (a_value),
        .d_value    (d_value),
        .out_m      (out_m),
        .zr         (zr),
        .ng         (ng),
        .write_m    (write_m),
        .exec_count (exec_count)
    );

    hack_core #(
        .ram_addr_w (ram_addr_w)
    ) i_hack_core (
        .clk_100MHz (clk_100MHz),
        .reset      (reset),
        .instr      (instr),
        .exec_valid (exec_valid),
        .a_value    (a_value),
        .d_value    (d_value),
        .out_m      (out_m),
        .zr         (zr),
        .ng         (ng),
        .write_m    (write_m),
        .exec_count (exec_count)
    );

endmodule

// File: test/hack_ref.svh
// Hack reference model: ALU, instruction step on a model state and a Galois LFSR
`ifndef hack_ref_svh
`define hack_ref_svh

logic [15:0] m_a;
logic [15:0] m_d;
logic [15:0] m_count;
logic [15:0] m_mem [0:(1<<ram_addr_w)-1];
logic [31:0] lfsr_state;

function automatic void ref_reset();
    m_a = 16'h0000;
    m_d = 16'h0000;
    m_count = 16'h0000;
    lfsr_state = 32'h1d37_3437;
    foreach (m_mem[i]) m_mem[i] = 16'h0000;
endfunction

// One step of the LFSR per bit handed out
function automatic logic lfsr_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h8020_0003 : 32'h0000_0000);
    return b;
endfunction

function automatic logic [15:0] lfsr_bits(input int n);
    logic [15:0] v;
    v = 16'h0000;
    for (int i = 0; i < n; i++) v = {v[14:0], lfsr_bit()};
    return v;
endfunction

// Control bits zx nx zy ny f no from c[5] down to c[0]
function automatic logic [15:0] alu_ref(input logic [15:0] x, input logic [15:0] y,
                                        input logic [5:0] c);
    logic [15:0] xv;
    logic [15:0] yv;
    logic [15:0] r;
    xv = c[5] ? 16'h0000 : x;
    xv = c[4] ? ~xv : xv;
    yv = c[3] ? 16'h0000 : y;
    yv = c[2] ? ~yv : yv;
    r = c[1] ? xv + yv : xv & yv;
    return c[0] ? ~r : r;
endfunction

// Returns write_m, ng, zr and out_m for the current model state
function automatic logic [18:0] predict(input logic [15:0] ins);
    logic [15:0] y;
    logic [15:0] r;
    y = ins[12] ? m_mem[m_a[ram_addr_w-1:0]] : m_a;
    r = alu_ref(m_d, y, ins[11:6]);
    return {ins[15] & ins[3], r[15], r == 16'h0000, r};
endfunction

function automatic void ref_commit(input logic [15:0] ins);
    logic [18:0] p;
    p = predict(ins);
    if (!ins[15]) begin
        m_a = {1'b0, ins[14:0]};
    end else begin
        // Memory address is the A value before this step
        if (ins[3]) m_mem[m_a[ram_addr_w-1:0]] = p[15:0];
        if (ins[4]) m_d = p[15:0];
        if (ins[5]) m_a = p[15:0];
    end
    m_count = m_count + 16'd1;
endfunction

`endif

// File: test/tb_hack.sv
// Hack CPU testbench: drives the APB register block and checks against a reference model
`timescale 1ns/1ns

module tb_hack
    import hack_pkg::*;
;

    localparam int ram_addr_w = 10;

    logic        clk_100MHz;
    logic        reset;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    int errors = 0;
    int checks = 0;
    int tests = 0;
    int test_base = 0;

    `include "hack_ref.svh"

    hack_top #(
        .ram_addr_w (ram_addr_w)
    ) i_hack_top (
        .clk_100MHz (clk_100MHz),
        .reset      (reset),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr)
    );

    always #5 clk_100MHz = ~clk_100MHz;

    // ============================================================
    // APB transfer and checks
    // ============================================================
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        int waited;
        @(negedge clk_100MHz);
        paddr = addr;
        pwrite = wr;
        pwdata = wdata;
        psel = 1'b1;
        @(negedge clk_100MHz);
        penable = 1'b1;
        #1;
        waited = 0;
        while (!pready && waited < 16) begin
            @(negedge clk_100MHz);
            #1;
            waited++;
        end
        if (pready) begin
            rdata = prdata;
            err = pslverr;
            @(negedge clk_100MHz);
            psel = 1'b0;
            penable = 1'b0;
        end else begin
            $display("No pready within 16 cycles of an APB access");
            $display("*** TEST FAILED ***");
            $finish;
        end
    endtask

    task automatic read_check(input string name, input logic [7:0] addr,
                              input logic [31:0] expected);
        logic [31:0] data;
        logic err;
        apb_xfer(1'b0, addr, 32'h0, data, err);
        checks++;
        if (err) begin
            $display("%s: read of offset %h was refused with pslverr", name, addr);
            errors++;
        end
        if (data !== expected) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, data);
            errors++;
        end
    endtask

    task automatic expect_pslverr(input string name, input logic err);
        checks++;
        if (!err) begin
            $display("%s: pslverr was not raised", name);
            errors++;
        end
    endtask

    task automatic exec_instr(input logic [15:0] ins);
        logic [31:0] unused;
        logic err;
        apb_xfer(1'b1, reg_instr, {16'h0000, ins}, unused, err);
        ref_commit(ins);
        if (err) begin
            $display("Instruction write %h was refused with pslverr", ins);
            errors++;
        end
    endtask

    // D takes dv through A, then A takes av
    task automatic load_ad(input logic [15:0] av, input logic [15:0] dv);
        exec_instr(dv);
        exec_instr(16'hEC10);
        exec_instr(av);
    endtask

    task automatic finish_test(input string name);
        $display("Test %-8s done, %0d errors", name, errors - test_base);
        test_base = errors;
        tests++;
    endtask

    // ============================================================
    // Stimulus
    // ============================================================
    initial begin
        logic [15:0] v;
        logic [15:0] ins;
        logic [15:0] start_count;
        logic [18:0] p;
        logic [31:0] rd;
        logic err;
        clk_100MHz = 1'b0;
        reset = 1'b1;
        paddr = 8'h00;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = 32'h0;
        ref_reset();
        repeat (3) @(negedge clk_100MHz);
        reset = 1'b0;

        // Instruction register holds 0, so the flags show D & A
        p = predict(16'h0000);
        read_check("reset_a", reg_a, 32'h0);
        read_check("reset_d", reg_d, 32'h0);
        read_check("reset_cnt", reg_exec_count, 32'h0);
        read_check("reset_st", reg_status, {29'h0, p[18:16]});
        finish_test("reset");

        v = lfsr_bits(15);
        exec_instr(v);
        read_check("ainst_ir", reg_instr, {16'h0, v});
        read_check("ainst_a", reg_a, {16'h0, m_a});
        read_check("ainst_d", reg_d, {16'h0, m_d});
        finish_test("a_instr");

        // No destinations, so the readback still shows the pre-commit result
        for (int c = 0; c < 64; c++) begin
            load_ad(lfsr_bits(15), lfsr_bits(15));
            ins = {3'b111, lfsr_bit(), c[5:0], 6'b000000};
            p = predict(ins);
            exec_instr(ins);
            read_check("comp_out", reg_out_m, {16'h0, p[15:0]});
            read_check("comp_st", reg_status, {29'h0, p[18:16]});
        end
        finish_test("comp");

        // M=D+1, D=0, then D=M
        load_ad(lfsr_bits(15), lfsr_bits(15));
        p = predict(16'hE7C8);
        exec_instr(16'hE7C8);
        read_check("mem_st", reg_status, {29'h0, p[18:16]});
        exec_instr(16'hEA90);
        exec_instr(16'hFC10);
        read_check("mem_d", reg_d, {16'h0, m_d});
        finish_test("memory");

        start_count = m_count;
        for (int n = 0; n < 200; n++) begin
            if (lfsr_bit()) begin
                v = lfsr_bits(13);
                ins = {3'b111, v[12:0]};
            end else begin
                ins = lfsr_bits(15);
            end
            exec_instr(ins);
            read_check("prog_a", reg_a, {16'h0, m_a});
            read_check("prog_d", reg_d, {16'h0, m_d});
        end
        read_check("prog_cnt", reg_exec_count, {16'h0, start_count + 16'd200});
        finish_test("program");

        apb_xfer(1'b0, 8'h18, 32'h0, rd, err);
        expect_pslverr("unmapped read", err);
        apb_xfer(1'b1, reg_a, {16'h0, ~m_a}, rd, err);
        expect_pslverr("write to reg_a", err);
        read_check("err_a", reg_a, {16'h0, m_a});
        read_check("err_cnt", reg_exec_count, {16'h0, m_count});
        finish_test("errors");

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+test
rtl/hack_pkg.sv
rtl/hack_alu.sv
rtl/hack_ram.sv
rtl/hack_core.sv
rtl/hack_apb_regs.sv
rtl/hack_top.sv
test/tb_hack.sv

// File: Makefile
TOP = tb_hack

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): all.f rtl/*.sv test/*.sv test/*.svh
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)
	verilator --lint-only --timing -f all.f --top-module hack_top

clean:
	rm -rf obj_dir
